/* verilog/pv2_dpath_pkg.sv */
/* Five-stage integer datapath shared definitions
   Widths, reset vector, mux and ALU codes, instruction layout */
package pv2_dpath_pkg;

  // Datapath and register index widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // First fetch after reset
  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0008_0000;

  // ------------------------------
  // Mux select codes
  // ------------------------------

  // Next PC source
  localparam logic [1:0] PC_SEL_PLUS4 = 2'd0;
  localparam logic [1:0] PC_SEL_BRANCH = 2'd1;
  localparam logic [1:0] PC_SEL_JUMP = 2'd2;
  localparam logic [1:0] PC_SEL_JUMPREG = 2'd3;

  // Source register forwarding
  localparam logic [1:0] BYP_SEL_RF = 2'd0;
  localparam logic [1:0] BYP_SEL_X = 2'd1;
  localparam logic [1:0] BYP_SEL_M = 2'd2;
  localparam logic [1:0] BYP_SEL_W = 2'd3;

  // Operand 0 source
  localparam logic [1:0] OP0_SEL_BYP = 2'd0;
  localparam logic [1:0] OP0_SEL_SHAMT = 2'd1;
  localparam logic [1:0] OP0_SEL_C16 = 2'd2;
  localparam logic [1:0] OP0_SEL_ZERO = 2'd3;

  // Operand 1 source
  localparam logic [2:0] OP1_SEL_BYP = 3'd0;
  localparam logic [2:0] OP1_SEL_ZEXT = 3'd1;
  localparam logic [2:0] OP1_SEL_SEXT = 3'd2;
  localparam logic [2:0] OP1_SEL_PC4 = 3'd3;
  localparam logic [2:0] OP1_SEL_ZERO = 3'd4;

  // ------------------------------
  // ALU functions
  // ------------------------------
  localparam logic [3:0] ALU_FN_ADD = 4'd0;
  localparam logic [3:0] ALU_FN_SUB = 4'd1;
  localparam logic [3:0] ALU_FN_SLL = 4'd2;
  localparam logic [3:0] ALU_FN_OR = 4'd3;
  localparam logic [3:0] ALU_FN_SLT = 4'd4;
  localparam logic [3:0] ALU_FN_SLTU = 4'd5;
  localparam logic [3:0] ALU_FN_AND = 4'd6;
  localparam logic [3:0] ALU_FN_XOR = 4'd7;
  localparam logic [3:0] ALU_FN_NOR = 4'd8;
  localparam logic [3:0] ALU_FN_SRL = 4'd9;
  localparam logic [3:0] ALU_FN_SRA = 4'd10;
  localparam logic [3:0] ALU_FN_LUI = 4'd11;

  // Load response extension
  localparam logic [2:0] LD_SEL_LW = 3'd0;
  localparam logic [2:0] LD_SEL_LB = 3'd1;
  localparam logic [2:0] LD_SEL_LBU = 3'd2;
  localparam logic [2:0] LD_SEL_LH = 3'd3;
  localparam logic [2:0] LD_SEL_LHU = 3'd4;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [4:0] shamt;
      logic [5:0] func;
    } r;
    struct packed {
      logic [5:0] opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0] opcode;
      logic [25:0] target;
    } j;
  } inst_t;

endpackage

/* verilog/pv2_alu.sv */
/* Integer ALU
   Add, subtract, logic, compare, shift and upper-immediate load */
module pv2_alu import pv2_dpath_pkg::*; (
  input  logic [XLEN-1:0] in0,
  input  logic [XLEN-1:0] in1,
  input  logic [3:0]      fn,
  output logic [XLEN-1:0] out
);

  // Shifts take their amount from in0
  logic [4:0] sh;

  assign sh = in0[4:0];

  always_comb begin
    case (fn)
      ALU_FN_ADD: out = in0 + in1;
      ALU_FN_SUB: out = in0 - in1;
      ALU_FN_OR: out = in0 | in1;
      ALU_FN_AND: out = in0 & in1;
      ALU_FN_XOR: out = in0 ^ in1;
      ALU_FN_NOR: out = ~(in0 | in1);
      // Compares give 0 or 1
      ALU_FN_SLT: out = {31'b0, $signed(in0) < $signed(in1)};
      ALU_FN_SLTU: out = {31'b0, in0 < in1};
      ALU_FN_SLL: out = in1 << sh;
      ALU_FN_SRL: out = in1 >> sh;
      ALU_FN_SRA: out = $unsigned($signed(in1) >>> sh);
      // Decode puts 16 on in0 for LUI
      ALU_FN_LUI: out = in1 << sh;
      default: out = '0;
    endcase
  end

endmodule

/* verilog/pv2_regfile.sv */
/* Register file
   32 words, two combinational reads, one write, register zero reads zero */
module pv2_regfile import pv2_dpath_pkg::*; (
  input  logic                  clk,
  input  logic [REG_ADDR_W-1:0] raddr0,
  input  logic [REG_ADDR_W-1:0] raddr1,
  input  logic                  wen,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [XLEN-1:0]       wdata,
  output logic [XLEN-1:0]       rdata0,
  output logic [XLEN-1:0]       rdata1
);

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  // Register zero never stored
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see only the old value on a same-cycle write
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

/* verilog/pv2_fetch.sv */
/* PC stage and fetch
   Next-PC mux, fetch PC register and PC+4 handed to decode */
module pv2_fetch import pv2_dpath_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [1:0]      pc_sel,
  input  logic            stall_f,
  input  logic            stall_d,
  input  logic [XLEN-1:0] branch_targ_x,
  input  logic [XLEN-1:0] jump_targ_d,
  input  logic [XLEN-1:0] jumpreg_targ_d,
  output logic [XLEN-1:0] imem_addr,
  output logic [XLEN-1:0] pc_plus4_d
);

  logic [XLEN-1:0] pc_f;
  logic [XLEN-1:0] pc_plus4_f;
  logic [XLEN-1:0] pc_next;

  assign pc_plus4_f = pc_f + 32'd4;

  // Branch target comes back from X and jumps from D
  always_comb begin
    case (pc_sel)
      PC_SEL_BRANCH: pc_next = branch_targ_x;
      PC_SEL_JUMP: pc_next = jump_targ_d;
      PC_SEL_JUMPREG: pc_next = jumpreg_targ_d;
      default: pc_next = pc_plus4_f;
    endcase
  end

  // Request goes out in the P stage ahead of the PC register
  assign imem_addr = reset ? RESET_VECTOR : pc_next;

  // F <- P
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_next;
    end
  end

  // D <- F
  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // First sequential fetch after reset continues from the reset vector
  reset_vector_a: assert property (@(posedge clk)
    $fell(reset) && pc_sel == PC_SEL_PLUS4 |-> imem_addr == RESET_VECTOR + 32'd4)
    else $error("first sequential fetch after reset does not follow the reset vector");

endmodule

/* verilog/pv2_decode.sv */
/* Decode stage
   Field decode, jump and branch targets, forwarding and operand muxes */
module pv2_decode import pv2_dpath_pkg::*; (
  input  logic [XLEN-1:0]       inst_d,
  input  logic [XLEN-1:0]       pc_plus4_d,
  input  logic [1:0]            op0_sel_d,
  input  logic [2:0]            op1_sel_d,
  input  logic [1:0]            byp0_sel_d,
  input  logic [1:0]            byp1_sel_d,
  input  logic [XLEN-1:0]       rf_rdata0,
  input  logic [XLEN-1:0]       rf_rdata1,
  input  logic [XLEN-1:0]       byp_x,
  input  logic [XLEN-1:0]       byp_m,
  input  logic [XLEN-1:0]       byp_w,
  output logic [REG_ADDR_W-1:0] rf_raddr0,
  output logic [REG_ADDR_W-1:0] rf_raddr1,
  output logic [XLEN-1:0]       op0_d,
  output logic [XLEN-1:0]       op1_d,
  output logic [XLEN-1:0]       wdata_d,
  output logic [XLEN-1:0]       branch_targ_d,
  output logic [XLEN-1:0]       jump_targ_d,
  output logic [XLEN-1:0]       jumpreg_targ_d
);

  inst_t inst;
  logic [XLEN-1:0] imm_zext;
  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] shamt;
  logic [XLEN-1:0] rs_val;
  logic [XLEN-1:0] rt_val;

  // Forwarding mux, same for both source registers
  function automatic logic [XLEN-1:0] byp_mux(
    input logic [1:0]      sel,
    input logic [XLEN-1:0] rf_val,
    input logic [XLEN-1:0] x_val,
    input logic [XLEN-1:0] m_val,
    input logic [XLEN-1:0] w_val
  );
    case (sel)
      BYP_SEL_X: return x_val;
      BYP_SEL_M: return m_val;
      BYP_SEL_W: return w_val;
      default: return rf_val;
    endcase
  endfunction

  // ------------------------------
  // Field decode
  // ------------------------------
  assign inst = inst_d;

  // Register indices and shamt in R layout
  assign rf_raddr0 = inst.r.rs;
  assign rf_raddr1 = inst.r.rt;
  assign shamt = {27'b0, inst.r.shamt};

  // Immediate in I layout
  assign imm_zext = {16'b0, inst.i.imm};
  assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};

  // Word-aligned targets
  assign branch_targ_d = pc_plus4_d + (imm_sext << 2);
  assign jump_targ_d = {pc_plus4_d[31:28], inst.j.target, 2'b00};

  // ------------------------------
  // Forwarding and operands
  // ------------------------------
  assign rs_val = byp_mux(byp0_sel_d, rf_rdata0, byp_x, byp_m, byp_w);
  assign rt_val = byp_mux(byp1_sel_d, rf_rdata1, byp_x, byp_m, byp_w);

  // rs feeds jr, rt is store data
  assign jumpreg_targ_d = rs_val;
  assign wdata_d = rt_val;

  // Operand 0: constant 16 serves LUI
  always_comb begin
    case (op0_sel_d)
      OP0_SEL_SHAMT: op0_d = shamt;
      OP0_SEL_C16: op0_d = 32'd16;
      OP0_SEL_ZERO: op0_d = '0;
      default: op0_d = rs_val;
    endcase
  end

  // Operand 1, PC+4 for link writes
  always_comb begin
    case (op1_sel_d)
      OP1_SEL_BYP: op1_d = rt_val;
      OP1_SEL_ZEXT: op1_d = imm_zext;
      OP1_SEL_SEXT: op1_d = imm_sext;
      OP1_SEL_PC4: op1_d = pc_plus4_d;
      default: op1_d = '0;
    endcase
  end

  op1_sel_legal_a: assert final ($isunknown(op1_sel_d) || op1_sel_d <= OP1_SEL_ZERO)
    else $error("op1_sel_d out of range: %0d", op1_sel_d);

endmodule

/* verilog/pv2_execute.sv */
/* Execute stage
   D to X registers, ALU, branch condition flags, data memory request */
module pv2_execute import pv2_dpath_pkg::*; (
  input  logic            clk,
  input  logic            stall_x,
  input  logic [XLEN-1:0] op0_d,
  input  logic [XLEN-1:0] op1_d,
  input  logic [XLEN-1:0] wdata_d,
  input  logic [XLEN-1:0] branch_targ_d,
  input  logic [3:0]      alu_fn_x,
  output logic [XLEN-1:0] alu_out_x,
  output logic [XLEN-1:0] branch_targ_x,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic            br_eq_x,
  output logic            br_zero_x,
  output logic            br_neg_x
);

  logic [XLEN-1:0] op0_x;
  logic [XLEN-1:0] op1_x;
  logic [XLEN-1:0] wdata_x;

  // X <- D
  always_ff @(posedge clk) begin
    if (!stall_x) begin
      op0_x <= op0_d;
      op1_x <= op1_d;
      wdata_x <= wdata_d;
      branch_targ_x <= branch_targ_d;
    end
  end

  pv2_alu u_alu (
    .in0 (op0_x),
    .in1 (op1_x),
    .fn  (alu_fn_x),
    .out (alu_out_x)
  );

  // Branch conditions for the controller
  assign br_eq_x = (alu_out_x == '0);
  assign br_zero_x = (op0_x == '0);
  assign br_neg_x = op0_x[XLEN-1];

  // Request issued in X, response arrives in M
  assign dmem_addr = alu_out_x;
  assign dmem_wdata = wdata_x;

endmodule

/* verilog/pv2_memory.sv */
/* Memory and writeback stages
   Load extension, response holding register, post-memory mux, W register */
module pv2_memory import pv2_dpath_pkg::*; (
  input  logic            clk,
  input  logic            stall_m,
  input  logic            stall_w,
  input  logic [XLEN-1:0] alu_out_x,
  input  logic [XLEN-1:0] dmem_rdata,
  input  logic [2:0]      ld_sel_m,
  input  logic            resp_hold_en_m,
  input  logic            resp_hold_use_m,
  input  logic            post_mem_sel_m,
  output logic [XLEN-1:0] post_mem_m,
  output logic [XLEN-1:0] wb_data
);

  logic [XLEN-1:0] alu_out_m;
  logic [XLEN-1:0] resp_ext;
  logic [XLEN-1:0] resp_hold;
  logic [XLEN-1:0] resp_m;

  // M <- X
  always_ff @(posedge clk) begin
    if (!stall_m) begin
      alu_out_m <= alu_out_x;
    end
  end

  // ------------------------------
  // Subword load extension
  // ------------------------------
  always_comb begin
    case (ld_sel_m)
      LD_SEL_LB: resp_ext = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
      LD_SEL_LBU: resp_ext = {24'b0, dmem_rdata[7:0]};
      LD_SEL_LH: resp_ext = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
      LD_SEL_LHU: resp_ext = {16'b0, dmem_rdata[15:0]};
      default: resp_ext = dmem_rdata;
    endcase
  end

  // One-entry holding register for a response that arrives under stall
  always_ff @(posedge clk) begin
    if (resp_hold_en_m) begin
      resp_hold <= resp_ext;
    end
  end

  assign resp_m = resp_hold_use_m ? resp_hold : resp_ext;

  // ALU result or load data, also the M bypass value
  assign post_mem_m = post_mem_sel_m ? resp_m : alu_out_m;

  // W <- M
  always_ff @(posedge clk) begin
    if (!stall_w) begin
      wb_data <= post_mem_m;
    end
  end

  // Holding register must be filled before its first use
  logic hold_seen = 1'b0;

  always_ff @(posedge clk) begin
    if (resp_hold_en_m) begin
      hold_seen <= 1'b1;
    end
  end

  hold_before_use_a: assert property (@(posedge clk) resp_hold_use_m |-> hold_seen)
    else $error("resp_hold_use_m high before any resp_hold_en_m");

endmodule

/* verilog/pv2_dpath_top.sv */
/* Five-stage integer datapath top level
   Fetch, decode, execute and memory stages around the register file */
module pv2_dpath_top import pv2_dpath_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  // PC select and per-stage stalls
  input  logic [1:0]            pc_sel,
  input  logic                  stall_f,
  input  logic                  stall_d,
  input  logic                  stall_x,
  input  logic                  stall_m,
  input  logic                  stall_w,
  // Decode and execute controls
  input  logic [XLEN-1:0]       inst_d,
  input  logic [1:0]            op0_sel_d,
  input  logic [2:0]            op1_sel_d,
  input  logic [1:0]            byp0_sel_d,
  input  logic [1:0]            byp1_sel_d,
  input  logic [3:0]            alu_fn_x,
  // Memory and writeback controls
  input  logic [2:0]            ld_sel_m,
  input  logic                  resp_hold_en_m,
  input  logic                  resp_hold_use_m,
  input  logic                  post_mem_sel_m,
  input  logic                  rf_wen_w,
  input  logic [REG_ADDR_W-1:0] rf_waddr_w,
  input  logic [XLEN-1:0]       dmem_rdata,
  // Memory ports, branch flags and writeback value
  output logic [XLEN-1:0]       imem_addr,
  output logic [XLEN-1:0]       dmem_addr,
  output logic [XLEN-1:0]       dmem_wdata,
  output logic                  br_eq_x,
  output logic                  br_zero_x,
  output logic                  br_neg_x,
  output logic [XLEN-1:0]       wb_data
);

  // ------------------------------
  // Inter-stage nets
  // ------------------------------

  // Fetch to decode
  logic [XLEN-1:0] pc_plus4_d;

  // Register file read ports
  logic [REG_ADDR_W-1:0] rf_raddr0;
  logic [REG_ADDR_W-1:0] rf_raddr1;
  logic [XLEN-1:0] rf_rdata0;
  logic [XLEN-1:0] rf_rdata1;

  // Decode results
  logic [XLEN-1:0] op0_d;
  logic [XLEN-1:0] op1_d;
  logic [XLEN-1:0] wdata_d;
  logic [XLEN-1:0] branch_targ_d;
  logic [XLEN-1:0] jump_targ_d;
  logic [XLEN-1:0] jumpreg_targ_d;

  // Later-stage values, also the bypass sources
  logic [XLEN-1:0] alu_out_x;
  logic [XLEN-1:0] branch_targ_x;
  logic [XLEN-1:0] post_mem_m;

  pv2_fetch u_fetch (
    .clk            (clk),
    .reset          (reset),
    .pc_sel         (pc_sel),
    .stall_f        (stall_f),
    .stall_d        (stall_d),
    .branch_targ_x  (branch_targ_x),
    .jump_targ_d    (jump_targ_d),
    .jumpreg_targ_d (jumpreg_targ_d),
    .imem_addr      (imem_addr),
    .pc_plus4_d     (pc_plus4_d)
  );

  pv2_decode u_decode (
    .inst_d         (inst_d),
    .pc_plus4_d     (pc_plus4_d),
    .op0_sel_d      (op0_sel_d),
    .op1_sel_d      (op1_sel_d),
    .byp0_sel_d     (byp0_sel_d),
    .byp1_sel_d     (byp1_sel_d),
    .rf_rdata0      (rf_rdata0),
    .rf_rdata1      (rf_rdata1),
    .byp_x          (alu_out_x),
    .byp_m          (post_mem_m),
    .byp_w          (wb_data),
    .rf_raddr0      (rf_raddr0),
    .rf_raddr1      (rf_raddr1),
    .op0_d          (op0_d),
    .op1_d          (op1_d),
    .wdata_d        (wdata_d),
    .branch_targ_d  (branch_targ_d),
    .jump_targ_d    (jump_targ_d),
    .jumpreg_targ_d (jumpreg_targ_d)
  );

  // Written from W, read in D
  pv2_regfile u_regfile (
    .clk    (clk),
    .raddr0 (rf_raddr0),
    .raddr1 (rf_raddr1),
    .wen    (rf_wen_w),
    .waddr  (rf_waddr_w),
    .wdata  (wb_data),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1)
  );

  pv2_execute u_execute (
    .clk           (clk),
    .stall_x       (stall_x),
    .op0_d         (op0_d),
    .op1_d         (op1_d),
    .wdata_d       (wdata_d),
    .branch_targ_d (branch_targ_d),
    .alu_fn_x      (alu_fn_x),
    .alu_out_x     (alu_out_x),
    .branch_targ_x (branch_targ_x),
    .dmem_addr     (dmem_addr),
    .dmem_wdata    (dmem_wdata),
    .br_eq_x       (br_eq_x),
    .br_zero_x     (br_zero_x),
    .br_neg_x      (br_neg_x)
  );

  pv2_memory u_memory (
    .clk             (clk),
    .stall_m         (stall_m),
    .stall_w         (stall_w),
    .alu_out_x       (alu_out_x),
    .dmem_rdata      (dmem_rdata),
    .ld_sel_m        (ld_sel_m),
    .resp_hold_en_m  (resp_hold_en_m),
    .resp_hold_use_m (resp_hold_use_m),
    .post_mem_sel_m  (post_mem_sel_m),
    .post_mem_m      (post_mem_m),
    .wb_data         (wb_data)
  );

endmodule

/* dv/pv2_dpath_tb.sv */
/* Datapath testbench
   Reference model of the five stages, directed and random stimulus, checking assertions */
module pv2_dpath_tb import pv2_dpath_pkg::*; ();

  logic clk;
  logic reset;
  logic [1:0] pc_sel;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic [31:0] inst_d;
  logic [1:0] op0_sel_d;
  logic [2:0] op1_sel_d;
  logic [1:0] byp0_sel_d, byp1_sel_d;
  logic [3:0] alu_fn_x;
  logic [2:0] ld_sel_m;
  logic resp_hold_en_m, resp_hold_use_m, post_mem_sel_m, rf_wen_w;
  logic [4:0] rf_waddr_w;
  logic [31:0] dmem_rdata;
  logic [31:0] imem_addr, dmem_addr, dmem_wdata, wb_data;
  logic br_eq_x, br_zero_x, br_neg_x;

  int err_count = 0;
  int n_pass = 0;
  int n_fail = 0;

  // Controller queues
  // M word is {post_sel, ld_sel, hold_en, hold_use, rdata}
  logic [3:0] fn_q;
  logic [37:0] mctl_q [2];
  logic [5:0] wctl_q [3];
  // Controls attached to the next issued instruction
  logic [37:0] nx_mctl;
  logic [5:0] nx_wctl;
  logic [1:0] nx_pc;
  logic nx_stall_f;

  pv2_dpath_top DUT (.*);

  always #4 clk = ~clk;

  // ------------------------------
  // Reference model
  // ------------------------------
  logic [31:0] r_pc_f, r_pc4_d, r_op0_x, r_op1_x, r_wd_x, r_bt_x, r_alu_m, r_hold, r_wb;
  logic [31:0] r_rf [32];
  inst_t r_inst;
  logic [31:0] r_sext, r_rs, r_rt, r_op0, r_op1, r_next, r_resp, r_post;
  logic [31:0] e_imem, e_alu;
  logic e_eq, e_zero, e_neg;

  function automatic logic [31:0] alu_ref(input logic [3:0] fn, input logic [31:0] a,
                                          input logic [31:0] b);
    case (fn)
      ALU_FN_ADD: return a + b;
      ALU_FN_SUB: return a + ~b + 32'd1;
      ALU_FN_OR: return a | b;
      ALU_FN_AND: return a & b;
      ALU_FN_XOR: return a ^ b;
      ALU_FN_NOR: return ~a & ~b;
      ALU_FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_FN_SRL: return b >> a[4:0];
      ALU_FN_SRA: return 32'($signed(b) >>> a[4:0]);
      ALU_FN_SLL, ALU_FN_LUI: return b << a[4:0];
      default: return 32'd0;
    endcase
  endfunction

  // Load extension by slice width and signedness
  function automatic logic [31:0] extend(input logic [2:0] sel, input logic [31:0] w);
    case (sel)
      LD_SEL_LB: return 32'($signed(w[7:0]));
      LD_SEL_LBU: return 32'(w[7:0]);
      LD_SEL_LH: return 32'($signed(w[15:0]));
      LD_SEL_LHU: return 32'(w[15:0]);
      default: return w;
    endcase
  endfunction

  always_comb begin
    r_inst = inst_d;
    r_sext = {{16{r_inst.i.imm[15]}}, r_inst.i.imm};
    e_alu = alu_ref(alu_fn_x, r_op0_x, r_op1_x);
    e_eq = (e_alu == 32'd0);
    e_zero = (r_op0_x == 32'd0);
    e_neg = r_op0_x[31];
    r_resp = resp_hold_use_m ? r_hold : extend(ld_sel_m, dmem_rdata);
    r_post = post_mem_sel_m ? r_resp : r_alu_m;
    // Sources with register zero read as zero
    case (byp0_sel_d)
      BYP_SEL_X: r_rs = e_alu;
      BYP_SEL_M: r_rs = r_post;
      BYP_SEL_W: r_rs = r_wb;
      default: r_rs = (r_inst.r.rs == 5'd0) ? 32'd0 : r_rf[r_inst.r.rs];
    endcase
    case (byp1_sel_d)
      BYP_SEL_X: r_rt = e_alu;
      BYP_SEL_M: r_rt = r_post;
      BYP_SEL_W: r_rt = r_wb;
      default: r_rt = (r_inst.r.rt == 5'd0) ? 32'd0 : r_rf[r_inst.r.rt];
    endcase
    case (op0_sel_d)
      OP0_SEL_SHAMT: r_op0 = {27'd0, r_inst.r.shamt};
      OP0_SEL_C16: r_op0 = 32'd16;
      OP0_SEL_ZERO: r_op0 = 32'd0;
      default: r_op0 = r_rs;
    endcase
    case (op1_sel_d)
      OP1_SEL_BYP: r_op1 = r_rt;
      OP1_SEL_ZEXT: r_op1 = {16'd0, r_inst.i.imm};
      OP1_SEL_SEXT: r_op1 = r_sext;
      OP1_SEL_PC4: r_op1 = r_pc4_d;
      default: r_op1 = 32'd0;
    endcase
    // Next fetch address
    case (pc_sel)
      PC_SEL_BRANCH: r_next = r_bt_x;
      PC_SEL_JUMP: r_next = {r_pc4_d[31:28], r_inst.j.target, 2'b00};
      PC_SEL_JUMPREG: r_next = r_rs;
      default: r_next = r_pc_f + 32'd4;
    endcase
    e_imem = reset ? RESET_VECTOR : r_next;
  end

  always @(posedge clk) begin
    if (reset) begin
      r_pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      r_pc_f <= r_next;
    end
    if (!stall_d) begin
      r_pc4_d <= r_pc_f + 32'd4;
    end
    if (!stall_x) begin
      r_op0_x <= r_op0;
      r_op1_x <= r_op1;
      r_wd_x <= r_rt;
      r_bt_x <= r_pc4_d + {r_sext[29:0], 2'b00};
    end
    if (!stall_m) begin
      r_alu_m <= e_alu;
    end
    if (resp_hold_en_m) begin
      r_hold <= extend(ld_sel_m, dmem_rdata);
    end
    if (!stall_w) begin
      r_wb <= r_post;
    end
    if (rf_wen_w && rf_waddr_w != 5'd0) begin
      r_rf[rf_waddr_w] <= r_wb;
    end
  end

  // ------------------------------
  // Checks against the model
  // ------------------------------
  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    err_count++;
  endtask

  imem_chk: assert property (@(posedge clk) !$isunknown(e_imem) |-> imem_addr == e_imem)
    else mismatch("imem_addr", $sampled(e_imem), $sampled(imem_addr));
  addr_chk: assert property (@(posedge clk) !$isunknown(e_alu) |-> dmem_addr == e_alu)
    else mismatch("dmem_addr", $sampled(e_alu), $sampled(dmem_addr));
  wdata_chk: assert property (@(posedge clk) !$isunknown(r_wd_x) |-> dmem_wdata == r_wd_x)
    else mismatch("dmem_wdata", $sampled(r_wd_x), $sampled(dmem_wdata));
  wb_chk: assert property (@(posedge clk) !$isunknown(r_wb) |-> wb_data == r_wb)
    else mismatch("wb_data", $sampled(r_wb), $sampled(wb_data));
  eq_chk: assert property (@(posedge clk) !$isunknown(e_alu) |-> br_eq_x == e_eq)
    else mismatch("br_eq_x", 32'($sampled(e_eq)), 32'($sampled(br_eq_x)));
  zero_chk: assert property (@(posedge clk) !$isunknown(r_op0_x) |-> br_zero_x == e_zero)
    else mismatch("br_zero_x", 32'($sampled(e_zero)), 32'($sampled(br_zero_x)));
  neg_chk: assert property (@(posedge clk) !$isunknown(r_op0_x) |-> br_neg_x == e_neg)
    else mismatch("br_neg_x", 32'($sampled(e_neg)), 32'($sampled(br_neg_x)));

  // ------------------------------
  // Controller
  // ------------------------------
  // One instruction into D while later-stage controls of older ones follow
  task automatic issue(input logic [31:0] inst, input logic [1:0] op0, input logic [2:0] op1,
                       input logic [1:0] b0, input logic [1:0] b1, input logic [3:0] fn);
    @(posedge clk);
    inst_d <= inst;
    op0_sel_d <= op0;
    op1_sel_d <= op1;
    byp0_sel_d <= b0;
    byp1_sel_d <= b1;
    pc_sel <= nx_pc;
    stall_f <= nx_stall_f;
    alu_fn_x <= fn_q;
    {post_mem_sel_m, ld_sel_m, resp_hold_en_m, resp_hold_use_m, dmem_rdata} <= mctl_q[1];
    {rf_wen_w, rf_waddr_w} <= wctl_q[2];
    fn_q = fn;
    mctl_q[1] = mctl_q[0];
    mctl_q[0] = nx_mctl;
    wctl_q[2] = wctl_q[1];
    wctl_q[1] = wctl_q[0];
    wctl_q[0] = nx_wctl;
    nx_mctl = '0;
    nx_wctl = '0;
    nx_pc = PC_SEL_PLUS4;
    nx_stall_f = 1'b0;
  endtask

  task automatic set_mem(input logic post, input logic [2:0] ld, input logic hen,
                         input logic huse, input logic [31:0] rdata);
    nx_mctl = {post, ld, hen, huse, rdata};
  endtask

  task automatic bubbles(input int n);
    repeat (n) issue(32'd0, OP0_SEL_ZERO, OP1_SEL_ZERO, BYP_SEL_RF, BYP_SEL_RF, ALU_FN_ADD);
  endtask

  // Full word built as LUI then OR with an optional write of the OR result
  task automatic load_const(input logic [31:0] v, input logic wen, input logic [4:0] rd);
    issue({16'h3c00, v[31:16]}, OP0_SEL_C16, OP1_SEL_ZEXT, BYP_SEL_RF, BYP_SEL_RF, ALU_FN_LUI);
    nx_wctl = {wen, rd};
    issue({16'h3400, v[15:0]}, OP0_SEL_BYP, OP1_SEL_ZEXT, BYP_SEL_X, BYP_SEL_RF, ALU_FN_OR);
  endtask

  task automatic wait_fetch_start();
    int n;
    n = 0;
    @(negedge clk);
    while (imem_addr == RESET_VECTOR && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (n >= 16) begin
      $display("Fetch address never left the reset vector after reset");
      err_count++;
    end
  endtask

  // Checks of the last edge report before the count is read
  task automatic end_test(input string name, input int errs_at_start);
    @(negedge clk);
    if (err_count == errs_at_start) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: failed with %0d errors", name, err_count - errs_at_start);
    end
  endtask

  // Hang guard
  initial begin
    repeat (4000) @(posedge clk);
    $display("Simulation timed out");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int e0;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] vals [8];
    void'($urandom(32'ha5c0));
    clk = 1'b0;
    reset = 1'b1;
    {pc_sel, stall_f, stall_d, stall_x, stall_m, stall_w} = '0;
    inst_d = '0;
    op0_sel_d = OP0_SEL_ZERO;
    op1_sel_d = OP1_SEL_ZERO;
    {byp0_sel_d, byp1_sel_d, alu_fn_x} = '0;
    {post_mem_sel_m, ld_sel_m, resp_hold_en_m, resp_hold_use_m, dmem_rdata} = '0;
    {rf_wen_w, rf_waddr_w} = '0;
    fn_q = ALU_FN_ADD;
    mctl_q = '{default: '0};
    wctl_q = '{default: '0};
    nx_mctl = '0;
    nx_wctl = '0;
    nx_pc = PC_SEL_PLUS4;
    nx_stall_f = 1'b0;

    // Reset, sequential fetch, fetch stall
    e0 = err_count;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    wait_fetch_start();
    bubbles(6);
    repeat (3) begin
      nx_stall_f = 1'b1;
      bubbles(1);
    end
    bubbles(3);
    end_test("reset and fetch", e0);

    // Jump, branch and jump-register redirects
    e0 = err_count;
    nx_pc = PC_SEL_JUMP;
    issue({6'h02, 26'($urandom)}, OP0_SEL_ZERO, OP1_SEL_ZERO, BYP_SEL_RF, BYP_SEL_RF, ALU_FN_ADD);
    issue({16'h1000, 16'($urandom)}, OP0_SEL_ZERO, OP1_SEL_ZERO, BYP_SEL_RF, BYP_SEL_RF,
          ALU_FN_ADD);
    nx_pc = PC_SEL_BRANCH;
    bubbles(1);
    issue({16'h2400, 16'($urandom)}, OP0_SEL_ZERO, OP1_SEL_SEXT, BYP_SEL_RF, BYP_SEL_RF,
          ALU_FN_ADD);
    nx_pc = PC_SEL_JUMPREG;
    issue(32'd0, OP0_SEL_ZERO, OP1_SEL_ZERO, BYP_SEL_X, BYP_SEL_RF, ALU_FN_ADD);
    bubbles(3);
    end_test("jump and branch targets", e0);

    // Every ALU code on random words with operands forwarded from W and X
    e0 = err_count;
    for (int fn = 0; fn < 12; fn++) begin
      a = $urandom;
      b = $urandom;
      if (fn == ALU_FN_SUB) b = a;
      if (fn == ALU_FN_AND) a = 32'd0;
      load_const(a, 1'b0, 5'd0);
      load_const(b, 1'b0, 5'd0);
      if (fn == ALU_FN_LUI) begin
        issue(32'd0, OP0_SEL_C16, OP1_SEL_BYP, BYP_SEL_W, BYP_SEL_X, 4'(fn));
      end else begin
        issue(32'd0, OP0_SEL_BYP, OP1_SEL_BYP, BYP_SEL_W, BYP_SEL_X, 4'(fn));
      end
    end
    bubbles(4);
    end_test("alu and flags", e0);

    // Writes through W including register zero and reads back
    e0 = err_count;
    for (int r = 0; r < 8; r++) begin
      vals[r] = $urandom;
      load_const(vals[r], 1'b1, 5'(r));
    end
    bubbles(4);
    for (int r = 0; r < 8; r++) begin
      issue({6'h00, 5'(r), 5'(r), 16'h0}, OP0_SEL_BYP, OP1_SEL_ZERO, BYP_SEL_RF, BYP_SEL_RF,
            ALU_FN_ADD);
    end
    bubbles(4);
    end_test("register write and read", e0);

    // Forwarding from each later stage
    e0 = err_count;
    for (int s = 1; s < 4; s++) begin
      repeat (3) begin
        issue({16'h2400, 16'($urandom)}, OP0_SEL_ZERO, OP1_SEL_SEXT, BYP_SEL_RF, BYP_SEL_RF,
              ALU_FN_ADD);
      end
      issue(32'd0, OP0_SEL_BYP, OP1_SEL_ZERO, 2'(s), 2'(s), ALU_FN_ADD);
    end
    bubbles(4);
    end_test("bypassing", e0);

    // Subword loads and then the holding register
    e0 = err_count;
    for (int l = 0; l < 5; l++) begin
      set_mem(1'b1, 3'(l), 1'b0, 1'b0, $urandom);
      bubbles(1);
    end
    set_mem(1'b1, LD_SEL_LH, 1'b1, 1'b0, $urandom);
    bubbles(2);
    set_mem(1'b1, LD_SEL_LW, 1'b0, 1'b1, $urandom);
    bubbles(5);
    end_test("loads and holding register", e0);

    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0 && err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/pv2_dpath_pkg.sv
verilog/pv2_alu.sv
verilog/pv2_regfile.sv
verilog/pv2_fetch.sv
verilog/pv2_decode.sv
verilog/pv2_execute.sv
verilog/pv2_memory.sv
verilog/pv2_dpath_top.sv
dv/pv2_dpath_tb.sv

/* Bender.yml */
package:
  name: pv2_dpath

sources:
  - verilog/pv2_dpath_pkg.sv
  - verilog/pv2_alu.sv
  - verilog/pv2_regfile.sv
  - verilog/pv2_fetch.sv
  - verilog/pv2_decode.sv
  - verilog/pv2_execute.sv
  - verilog/pv2_memory.sv
  - verilog/pv2_dpath_top.sv
  - target: test
    files:
      - dv/pv2_dpath_tb.sv
